/* Makefile */
SIM := obj_dir/Vring_subsys_tb

.PHONY: all run clean

all: run

$(SIM): compile.f $(wildcard hw/*.sv hw/*.svh dv/*.sv)
	verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
	  -f compile.f --top-module ring_subsys_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* compile.f */
+incdir+hw
hw/racc_pkg.sv
hw/ring_ldst_port.sv
hw/ring_mem_target.sv
hw/ring_subsys_top.sv
dv/ring_subsys_tb.sv

/* dv/ring_subsys_tb.sv */
`default_nettype none

`include "racc_macros.svh"

module ring_subsys_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW = $clog2(`RACC_MEM_WORDS);
  localparam int WAIT_LIMIT = 1000;
  // A row waits until idle, issues and moves on, or expects a permanent stall
  localparam logic [1:0] K_WAIT = 2'd0;
  localparam logic [1:0] K_GO   = 2'd1;
  localparam logic [1:0] K_HANG = 2'd2;

  typedef struct packed {
    logic        core;
    logic [1:0]  slice;
    logic        wr;
    logic [17:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [3:0]  wb;
    logic [1:0]  kind;
  } row_t;

  logic        CLK;
  logic        RST;
  logic [1:0]  slice_d [2];
  logic        cs_d [2];
  logic [17:0] addr_d [2];
  logic        wr_d [2];
  logic [3:0]  mask_d [2];
  logic [31:0] wdata_d [2];
  logic [3:0]  wb_d [2];
  logic [3:0]  stall_0;
  logic [3:0]  stall_1;
  logic        load_vld_0;
  logic        load_vld_1;
  logic [1:0]  load_slice_0;
  logic [1:0]  load_slice_1;
  logic [3:0]  load_sel_0;
  logic [3:0]  load_sel_1;
  logic [31:0] load_data_0;
  logic [31:0] load_data_1;

  row_t        rows [$];
  logic [31:0] ref_mem [`RACC_MEM_WORDS];
  logic        exp_rd [2][4];
  logic [31:0] exp_data [2][4];
  logic [3:0]  exp_sel [2][4];
  // Threads that took an address error, kept as a thread mask per core
  logic [3:0]  hung [2];
  logic [31:0] lfsr;
  int          errors;
  int          timeouts;

  ring_subsys_top ring_subsys_top_i (
    .CLK(CLK), .RST(RST),
    .slice_0(slice_d[0]), .cs_0(cs_d[0]), .addr_0(addr_d[0]), .wr_0(wr_d[0]),
    .mask_0(mask_d[0]), .wdata_0(wdata_d[0]), .wb_reg_0(wb_d[0]), .stall_0(stall_0),
    .load_vld_0(load_vld_0), .load_slice_0(load_slice_0), .load_sel_0(load_sel_0),
    .load_data_0(load_data_0),
    .slice_1(slice_d[1]), .cs_1(cs_d[1]), .addr_1(addr_d[1]), .wr_1(wr_d[1]),
    .mask_1(mask_d[1]), .wdata_1(wdata_d[1]), .wb_reg_1(wb_d[1]), .stall_1(stall_1),
    .load_vld_1(load_vld_1), .load_slice_1(load_slice_1), .load_sel_1(load_sel_1),
    .load_data_1(load_data_1)
  );

  always #5 CLK = ~CLK;

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1 that steps once per bit
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [3:0] stall_of_core(input logic c);
    return c ? stall_1 : stall_0;
  endfunction

  task automatic add_row(input logic c, input logic [1:0] s, input logic w,
                         input logic [17:0] a, input logic [3:0] m, input logic [31:0] d,
                         input logic [3:0] wb, input logic [1:0] k);
    rows.push_back(row_t'{c, s, w, a, m, d, wb, k});
  endtask

  // Reads only hit words that were fully written earlier in the sequence
  task automatic add_random_row(inout logic [15:0] known);
    logic        c;
    logic [1:0]  s;
    logic        w;
    logic [3:0]  ai;
    logic [3:0]  m;
    logic [31:0] d;
    logic [3:0]  wb;
    c  = 1'(rand_bits(1));
    s  = 2'(rand_bits(2));
    w  = 1'(rand_bits(1));
    ai = 4'(rand_bits(4));
    m  = 4'(rand_bits(4));
    d  = rand_bits(32);
    wb = 4'(rand_bits(4));
    if (!known[ai] || (w && m == 4'd0))
    begin
      w = 1'b1;
      m = 4'hf;
    end
    if (!w)
      m = 4'd0;
    known[ai] = known[ai] | w;
    add_row(c, s, w, {10'd0, 4'h5, ai}, m, d, wb, K_WAIT);
  endtask

  task automatic check_load(input logic c, input logic vld, input logic [1:0] ls,
                            input logic [3:0] sel, input logic [31:0] data);
    if (vld)
    begin
      assert (exp_rd[c][ls])
      else
      begin
        errors++;
        $display("[ERROR] %0t: core %0d load for slice %0d with no read pending",
                 $time, c, ls);
      end
      if (exp_rd[c][ls])
        assert (data === exp_data[c][ls] && sel === exp_sel[c][ls])
        else
        begin
          errors++;
          $display("[ERROR] %0t: core %0d slice %0d got %h reg %0d, expected %h reg %0d",
                   $time, c, ls, data, sel, exp_data[c][ls], exp_sel[c][ls]);
        end
      exp_rd[c][ls] = 1'b0;
    end
  endtask

  // All sampling and driving happens on the falling edge
  task automatic next_cycle();
    @(negedge CLK);
    check_load(1'b0, load_vld_0, load_slice_0, load_sel_0, load_data_0);
    check_load(1'b1, load_vld_1, load_slice_1, load_sel_1, load_data_1);
  endtask

  task automatic send_request(input row_t r);
    logic [1:0] thr;
    logic [3:0] st;
    int         cnt;
    thr = r.slice ^ 2'b10;
    cnt = 0;
    st  = stall_of_core(r.core);
    while (st[thr] && timeouts == 0)
    begin
      next_cycle();
      st = stall_of_core(r.core);
      cnt++;
      if (cnt >= WAIT_LIMIT)
      begin
        timeouts++;
        $display("Timeout: core %0d slice %0d never became free", r.core, r.slice);
      end
    end
    if (timeouts == 0)
    begin
      if (r.wr)
      begin
        for (int b = 0; b < 4; b++)
          if (r.mask[b])
            ref_mem[r.addr[AW-1:0]][8*b +: 8] = r.data[8*b +: 8];
      end
      else if (r.kind != K_HANG)
      begin
        exp_rd[r.core][r.slice]   = 1'b1;
        exp_data[r.core][r.slice] = ref_mem[r.addr[AW-1:0]];
        exp_sel[r.core][r.slice]  = r.wb;
      end
      slice_d[r.core] = r.slice;
      addr_d[r.core]  = r.addr;
      wr_d[r.core]    = r.wr;
      mask_d[r.core]  = r.mask;
      wdata_d[r.core] = r.data;
      wb_d[r.core]    = r.wb;
      cs_d[r.core]    = 1'b1;
      next_cycle();
      cs_d[r.core]    = 1'b0;
    end
  endtask

  task automatic wait_all_done();
    int cnt;
    cnt = 0;
    while (((stall_0 & ~hung[0]) != 4'd0 || (stall_1 & ~hung[1]) != 4'd0) && timeouts == 0)
    begin
      next_cycle();
      cnt++;
      if (cnt >= WAIT_LIMIT)
      begin
        timeouts++;
        $display("Timeout: requests still outstanding after %0d cycles", WAIT_LIMIT);
      end
    end
  endtask

  task automatic check_stays_stalled(input row_t r);
    logic [1:0] thr;
    logic [3:0] st;
    thr = r.slice ^ 2'b10;
    hung[r.core][thr] = 1'b1;
    repeat (50)
    begin
      next_cycle();
      st = stall_of_core(r.core);
      assert (st[thr])
      else
      begin
        errors++;
        $display("[ERROR] %0t: core %0d slice %0d stall fell after an address error",
                 $time, r.core, r.slice);
      end
    end
  endtask

  initial
  begin
    logic [15:0] known;
    CLK = 1'b0;
    RST = 1'b1;
    slice_d = '{default: 2'd0};
    cs_d = '{default: 1'b0};
    addr_d = '{default: 18'd0};
    wr_d = '{default: 1'b0};
    mask_d = '{default: 4'd0};
    wdata_d = '{default: 32'd0};
    wb_d = '{default: 4'd0};
    exp_rd = '{default: '{default: 1'b0}};
    hung = '{default: 4'd0};
    lfsr = 32'ha92a;
    errors = 0;
    timeouts = 0;
    known = '0;

    // Full-word write and read back on every thread of core 0
    add_row(1'b0, 2'd0, 1'b1, 18'h010, 4'hf, 32'h1357_9bdf, 4'd1, K_WAIT);
    add_row(1'b0, 2'd0, 1'b0, 18'h010, 4'h0, 32'h0, 4'd5, K_WAIT);
    add_row(1'b0, 2'd1, 1'b1, 18'h011, 4'hf, 32'h2468_ace0, 4'd2, K_WAIT);
    add_row(1'b0, 2'd1, 1'b0, 18'h011, 4'h0, 32'h0, 4'd6, K_WAIT);
    add_row(1'b0, 2'd2, 1'b1, 18'h012, 4'hf, 32'hfeed_f00d, 4'd3, K_WAIT);
    add_row(1'b0, 2'd2, 1'b0, 18'h012, 4'h0, 32'h0, 4'd7, K_WAIT);
    add_row(1'b0, 2'd3, 1'b1, 18'h013, 4'hf, 32'h0bad_c0de, 4'd4, K_WAIT);
    add_row(1'b0, 2'd3, 1'b0, 18'h013, 4'h0, 32'h0, 4'd8, K_WAIT);
    // Byte and half-word merges on core 1
    add_row(1'b1, 2'd2, 1'b1, 18'h030, 4'hf, 32'hdead_beef, 4'd2, K_WAIT);
    add_row(1'b1, 2'd2, 1'b1, 18'h030, 4'h1, 32'h0000_0011, 4'd2, K_WAIT);
    add_row(1'b1, 2'd3, 1'b1, 18'h030, 4'hc, 32'h7788_0000, 4'd3, K_WAIT);
    add_row(1'b1, 2'd0, 1'b1, 18'h030, 4'h4, 32'h0066_0000, 4'd4, K_WAIT);
    add_row(1'b1, 2'd1, 1'b0, 18'h030, 4'h0, 32'h0, 4'd9, K_WAIT);
    // Both cores stay in flight together while writes keep the target busy
    add_row(1'b0, 2'd0, 1'b1, 18'h040, 4'hf, 32'hcafe_0001, 4'd1, K_GO);
    add_row(1'b1, 2'd0, 1'b1, 18'h041, 4'hf, 32'hcafe_0002, 4'd2, K_GO);
    add_row(1'b0, 2'd1, 1'b1, 18'h042, 4'hf, 32'hcafe_0003, 4'd3, K_GO);
    add_row(1'b1, 2'd1, 1'b0, 18'h010, 4'h0, 32'h0, 4'd4, K_GO);
    add_row(1'b0, 2'd2, 1'b0, 18'h011, 4'h0, 32'h0, 4'd5, K_GO);
    add_row(1'b1, 2'd2, 1'b1, 18'h043, 4'hf, 32'hcafe_0004, 4'd6, K_GO);
    add_row(1'b0, 2'd3, 1'b0, 18'h012, 4'h0, 32'h0, 4'd7, K_GO);
    add_row(1'b1, 2'd3, 1'b0, 18'h030, 4'h0, 32'h0, 4'd8, K_WAIT);
    add_row(1'b0, 2'd0, 1'b0, 18'h040, 4'h0, 32'h0, 4'd10, K_GO);
    add_row(1'b1, 2'd0, 1'b0, 18'h041, 4'h0, 32'h0, 4'd11, K_GO);
    add_row(1'b0, 2'd1, 1'b0, 18'h042, 4'h0, 32'h0, 4'd12, K_GO);
    add_row(1'b1, 2'd1, 1'b0, 18'h043, 4'h0, 32'h0, 4'd13, K_WAIT);
    for (int i = 0; i < 60; i++)
      add_random_row(known);
    // Out-of-range read hangs its thread, a neighbor thread still works
    add_row(1'b0, 2'd1, 1'b0, 18'(`RACC_MEM_WORDS + 5), 4'h0, 32'h0, 4'd7, K_HANG);
    add_row(1'b0, 2'd2, 1'b1, 18'h060, 4'hf, 32'h5a5a_0f0f, 4'd1, K_WAIT);
    add_row(1'b0, 2'd3, 1'b0, 18'h060, 4'h0, 32'h0, 4'd14, K_WAIT);

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    assert (stall_0 == 4'd0 && stall_1 == 4'd0 && !load_vld_0 && !load_vld_1
            && ring_subsys_top_i.ring_p0_p1 == '0 && ring_subsys_top_i.ring_p1_tgt == '0
            && ring_subsys_top_i.ring_tgt_p0 == '0)
    else
    begin
      errors++;
      $display("[ERROR] %0t: stall, load_vld or ring not idle after reset", $time);
    end

    foreach (rows[i])
    begin
      if (timeouts == 0)
      begin
        send_request(rows[i]);
        if (rows[i].kind == K_WAIT)
          wait_all_done();
        else if (rows[i].kind == K_HANG)
          check_stays_stalled(rows[i]);
      end
    end

    foreach (exp_rd[c, t])
      assert (!exp_rd[c][t])
      else
      begin
        errors++;
        $display("Read on core %0d slice %0d never returned its data", c, t);
      end

    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/racc_macros.svh */
`ifndef RACC_MACROS_SVH
`define RACC_MACROS_SVH

// Flag bits at the top of every ring word
`define RACC_W_VALID 63
`define RACC_W_REQ 62

// Upper six ID bits carry the core, the lower two the thread
`define RACC_W_ID_HI 61
`define RACC_W_ID_LO 54

// Byte mask in a request, status in a response
`define RACC_W_MASK_HI 53
`define RACC_W_MASK_LO 50

// The word address sits just above the data
`define RACC_W_ADDR_HI 49
`define RACC_W_ADDR_LO 32

`define RACC_MEM_WORDS 256
`define RACC_WR_BUSY 2

`endif

/* hw/racc_pkg.sv */
`default_nettype none

`include "racc_macros.svh"

package racc_pkg;

  // Zero is an ack, anything else tells the issuer the access failed
  typedef enum logic [`RACC_W_MASK_HI-`RACC_W_MASK_LO:0] {
    RACC_OK       = 4'd0,
    RACC_ADDR_ERR = 4'd1
  } racc_status_e;

  // How the target reads a word; a zero mask is a read
  typedef struct packed {
    logic                                       valid;
    logic                                       req;
    logic [`RACC_W_ID_HI-`RACC_W_ID_LO:0]       id;
    logic [`RACC_W_MASK_HI-`RACC_W_MASK_LO:0]   mask;
    logic [`RACC_W_ADDR_HI-`RACC_W_ADDR_LO:0]   addr;
    logic [`RACC_W_ADDR_LO-1:0]                 wdata;
  } racc_req_t;

  // How a port reads a word coming back to it
  typedef struct packed {
    logic                                       valid;
    logic                                       req;
    logic [`RACC_W_ID_HI-`RACC_W_ID_LO:0]       id;
    racc_status_e                               status;
    logic [`RACC_W_ADDR_HI-`RACC_W_ADDR_LO:0]   addr;
    logic [`RACC_W_ADDR_LO-1:0]                 rdata;
  } racc_rsp_t;

  typedef union packed {
    racc_req_t req;
    racc_rsp_t rsp;
  } racc_word_t;

endpackage

`default_nettype wire

/* hw/ring_ldst_port.sv */
`default_nettype none

`include "racc_macros.svh"

module ring_ldst_port
  import racc_pkg::*;
#(
  parameter logic [5:0] CORE_ID = 6'd1
)
(
  input  wire logic        CLK,
  input  wire logic        RST,
  input  wire logic [1:0]  slice,
  input  wire logic        cs,
  // Addresses count 32-bit words
  input  wire logic [17:0] addr,
  input  wire logic        wr,
  input  wire logic [3:0]  mask,
  input  wire logic [31:0] wdata,
  input  wire logic [3:0]  wb_reg,
  output logic [3:0]       stall,
  output logic             load_vld,
  output logic [1:0]       load_slice,
  output logic [3:0]       load_sel,
  output logic [31:0]      load_data,
  input  wire racc_word_t  ring_in,
  output racc_word_t       ring_out
);

  racc_word_t  ring_in_q;
  racc_word_t  ring_out_q;

  logic [3:0]  pending;
  logic [3:0]  sent;
  logic [3:0]  hang;
  logic [3:0]  req_vec;
  logic [3:0]  rsp_hit;
  logic [3:0]  retry_hit;
  logic [3:0]  err_hit;
  logic [3:0]  send_now;
  logic [1:0]  slot;
  logic [1:0]  cs_thr;
  logic [1:0]  in_thr;
  logic        in_valid;
  logic        in_req;
  logic        in_own;
  logic        in_foreign;

  // Each thread has one transaction slot that loads on cs
  logic [17:0] addr_q [4];
  logic [3:0]  mask_q [4];
  logic [31:0] data_q [4];
  logic [3:0]  rc_q   [4];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      ring_in_q <= '0;
    else
      ring_in_q <= ring_in;
  end

  // The barrel issues slices 0..3 for threads 2, 3, 0, 1
  assign cs_thr = slice ^ 2'b10;

  // Flag bits are read off the raw word, the rest goes through the response view
  assign in_valid   = ring_in_q[`RACC_W_VALID];
  assign in_req     = ring_in_q[`RACC_W_REQ];
  assign in_thr     = ring_in_q.rsp.id[1:0];
  assign in_own     = in_valid && (ring_in_q.rsp.id[7:2] == CORE_ID);
  assign in_foreign = in_valid && !in_own;

  always_comb
  begin
    req_vec   = '0;
    rsp_hit   = '0;
    retry_hit = '0;
    if (cs)
      req_vec[cs_thr] = 1'b1;
    // A request of ours that comes all the way round was refused by the target
    if (in_own && in_req)
      retry_hit[in_thr] = 1'b1;
    if (in_own && !in_req)
      rsp_hit[in_thr] = 1'b1;
  end

  assign err_hit = (ring_in_q.rsp.status != RACC_OK) ? rsp_hit : 4'd0;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      pending <= '0;
      sent    <= '0;
      hang    <= '0;
    end
    else
    begin
      pending <= (pending & ~rsp_hit) | req_vec;
      sent    <= (sent | send_now) & ~rsp_hit & ~retry_hit;
      // Errors are not recovered, the thread sits here until reset
      hang    <= hang | err_hit;
    end
  end

  assign stall = pending | hang;

  always_ff @(posedge CLK)
  begin
    if (cs)
    begin
      addr_q[cs_thr] <= addr;
      mask_q[cs_thr] <= wr ? mask : 4'd0;
      data_q[cs_thr] <= wdata;
      rc_q[cs_thr]   <= wb_reg;
    end
  end

  // Only the thread owning the current slot may send, and only into a free slot
  always_comb
  begin
    send_now = '0;
    if (!in_foreign && pending[slot] && !sent[slot])
      send_now[slot] = 1'b1;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      slot       <= '0;
      ring_out_q <= '0;
    end
    else
    begin
      slot <= slot + 2'd1;
      if (in_foreign)
        ring_out_q <= ring_in_q;
      else if (|send_now)
        ring_out_q.req <= '{
          valid: 1'b1,
          req:   1'b1,
          id:    {CORE_ID, slot},
          mask:  mask_q[slot],
          addr:  addr_q[slot],
          wdata: data_q[slot]
        };
      else
        ring_out_q <= '0;
    end
  end

  assign ring_out = ring_out_q;

  // Stores complete silently, only reads go back to the register file
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      load_vld <= 1'b0;
    else
      load_vld <= (|(rsp_hit & ~err_hit)) && (mask_q[in_thr] == 4'd0);
  end

  always_ff @(posedge CLK)
  begin
    load_slice <= in_thr ^ 2'b10;
    load_sel   <= rc_q[in_thr];
    load_data  <= ring_in_q.rsp.rdata;
  end

  a_no_cs_when_stalled: assert property (
    @(posedge CLK) disable iff (RST)
    cs |-> !stall[cs_thr]
  );

  // Load data only ever answers a read that was still outstanding
  a_load_is_read: assert property (
    @(posedge CLK) disable iff (RST)
    load_vld |-> (mask_q[load_slice ^ 2'b10] == 4'd0) && $past(pending[in_thr])
  );

endmodule

`default_nettype wire

/* hw/ring_mem_target.sv */
`default_nettype none

`include "racc_macros.svh"

module ring_mem_target
  import racc_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       RST,
  input  wire racc_word_t ring_in,
  output racc_word_t      ring_out
);

  localparam int AW = $clog2(`RACC_MEM_WORDS);
  localparam int BW = $clog2(`RACC_WR_BUSY + 1);

  racc_word_t    ring_in_q;
  racc_word_t    ring_out_q;
  logic [31:0]   mem [`RACC_MEM_WORDS];
  logic [BW-1:0] busy_cnt;
  logic [AW-1:0] idx;
  logic [31:0]   rd_word;
  logic          is_req;
  logic          in_range;
  logic          serve;
  logic          do_write;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      ring_in_q <= '0;
    else
      ring_in_q <= ring_in;
  end

  assign is_req   = ring_in_q.req.valid && ring_in_q.req.req;
  assign in_range = ring_in_q.req.addr < 18'(`RACC_MEM_WORDS);
  // While busy the request stays a request and its issuer will resend it
  assign serve    = is_req && (busy_cnt == '0);
  assign do_write = serve && in_range && (ring_in_q.req.mask != 4'd0);
  assign idx      = ring_in_q.req.addr[AW-1:0];
  assign rd_word  = mem[idx];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      busy_cnt <= '0;
    else if (do_write)
      busy_cnt <= BW'(`RACC_WR_BUSY);
    else if (busy_cnt != '0)
      busy_cnt <= busy_cnt - 1'b1;
  end

  always_ff @(posedge CLK)
  begin
    if (do_write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (ring_in_q.req.mask[b])
          mem[idx][8*b +: 8] <= ring_in_q.req.wdata[8*b +: 8];
      end
    end
  end

  // The answer takes the slot the request arrived in
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      ring_out_q <= '0;
    else if (serve)
      ring_out_q.rsp <= '{
        valid:  1'b1,
        req:    1'b0,
        id:     ring_in_q.req.id,
        status: in_range ? RACC_OK : RACC_ADDR_ERR,
        addr:   ring_in_q.req.addr,
        rdata:  in_range ? rd_word : 32'd0
      };
    else
      ring_out_q <= ring_in_q;
  end

  assign ring_out = ring_out_q;

  a_err_only_out_of_range: assert property (
    @(posedge CLK) disable iff (RST)
    (ring_out_q.rsp.valid && !ring_out_q.rsp.req && ring_out_q.rsp.status != RACC_OK)
      |-> $past(!ring_in_q.req.req || !in_range)
  );

endmodule

`default_nettype wire

/* hw/ring_subsys_top.sv */
`default_nettype none

module ring_subsys_top
  import racc_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        RST,
  input  wire logic [1:0]  slice_0,
  input  wire logic        cs_0,
  input  wire logic [17:0] addr_0,
  input  wire logic        wr_0,
  input  wire logic [3:0]  mask_0,
  input  wire logic [31:0] wdata_0,
  input  wire logic [3:0]  wb_reg_0,
  output logic [3:0]       stall_0,
  output logic             load_vld_0,
  output logic [1:0]       load_slice_0,
  output logic [3:0]       load_sel_0,
  output logic [31:0]      load_data_0,
  input  wire logic [1:0]  slice_1,
  input  wire logic        cs_1,
  input  wire logic [17:0] addr_1,
  input  wire logic        wr_1,
  input  wire logic [3:0]  mask_1,
  input  wire logic [31:0] wdata_1,
  input  wire logic [3:0]  wb_reg_1,
  output logic [3:0]       stall_1,
  output logic             load_vld_1,
  output logic [1:0]       load_slice_1,
  output logic [3:0]       load_sel_1,
  output logic [31:0]      load_data_1
);

  // Ring runs core 0, core 1, target and back to core 0
  racc_word_t ring_p0_p1;
  racc_word_t ring_p1_tgt;
  racc_word_t ring_tgt_p0;

  ring_ldst_port #(.CORE_ID(6'd1)) port0_i (
    .CLK(CLK), .RST(RST), .slice(slice_0), .cs(cs_0), .addr(addr_0), .wr(wr_0),
    .mask(mask_0), .wdata(wdata_0), .wb_reg(wb_reg_0), .stall(stall_0),
    .load_vld(load_vld_0), .load_slice(load_slice_0), .load_sel(load_sel_0),
    .load_data(load_data_0), .ring_in(ring_tgt_p0), .ring_out(ring_p0_p1)
  );

  ring_ldst_port #(.CORE_ID(6'd2)) port1_i (
    .CLK(CLK), .RST(RST), .slice(slice_1), .cs(cs_1), .addr(addr_1), .wr(wr_1),
    .mask(mask_1), .wdata(wdata_1), .wb_reg(wb_reg_1), .stall(stall_1),
    .load_vld(load_vld_1), .load_slice(load_slice_1), .load_sel(load_sel_1),
    .load_data(load_data_1), .ring_in(ring_p0_p1), .ring_out(ring_p1_tgt)
  );

  ring_mem_target tgt_i (
    .CLK(CLK), .RST(RST), .ring_in(ring_p1_tgt), .ring_out(ring_tgt_p0)
  );

endmodule

`default_nettype wire
